// File: common/core_config.svh
`ifndef CORE_CONFIG_SVH
`define CORE_CONFIG_SVH

////////////////////////////////////////
// core sizing
////////////////////////////////////////

// data word width in bits
`define CORE_XLEN 32

// architectural register count, r0 included
`define CORE_NREG 32

// accepting edge to wb output, in cycles
`define CORE_WB_LAT 3

`endif

// File: common/isa_pkg.sv
`default_nettype none

`include "core_config.svh"

package isa_pkg;

    ////////////////////////////////////////
    // instruction set encodings
    ////////////////////////////////////////

    // register index
    typedef logic [$clog2(`CORE_NREG)-1:0] reg_addr_t;

    // major opcode, bits 31:26
    typedef enum logic [5:0] {
        OP_RTYPE = 6'h00,
        OP_ADDI  = 6'h08,
        OP_ORI   = 6'h0d,
        OP_LLO   = 6'h18,
        OP_LHI   = 6'h19
    } opcode_e;

    // r-type function, bits 5:0
    typedef enum logic [5:0] {
        FN_ADD = 6'h20,
        FN_SUB = 6'h22,
        FN_AND = 6'h24,
        FN_OR  = 6'h25,
        FN_XOR = 6'h26,
        FN_SLT = 6'h2a
    } funct_e;

    // internal alu operation, one per instruction
    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_ADDI,
        ALU_ORI,
        ALU_LHI,
        ALU_LLO
    } alu_op_e;

    // register format
    typedef struct packed {
        opcode_e   opcode;
        reg_addr_t rs;
        reg_addr_t rt;
        reg_addr_t rd;
        logic [4:0] shamt;
        funct_e    funct;
    } r_fields_t;

    // immediate format
    typedef struct packed {
        opcode_e     opcode;
        reg_addr_t   rs;
        reg_addr_t   rt;
        logic [15:0] imm;
    } i_fields_t;

    // one word, two views, picked by opcode
    typedef union packed {
        r_fields_t r_fields;
        i_fields_t i_fields;
    } instr_u;

endpackage

`default_nettype wire

// File: common/pipe_pkg.sv
`default_nettype none

`include "core_config.svh"

package pipe_pkg;

    ////////////////////////////////////////
    // datapath words
    ////////////////////////////////////////

    // one data word
    typedef logic [`CORE_XLEN-1:0] word_t;

    // one enable bit per byte lane
    typedef logic [`CORE_XLEN/8-1:0] byte_en_t;

    ////////////////////////////////////////
    // stage contents
    ////////////////////////////////////////

    // decoded fields, no register data yet
    typedef struct packed {
        logic               valid;
        isa_pkg::reg_addr_t rs_addr;
        isa_pkg::reg_addr_t rt_addr;
        // destination, rd or rt
        isa_pkg::reg_addr_t rd_addr;
        logic [15:0]        imm;
        isa_pkg::alu_op_e   alu_op;
        // bytes the result will write
        byte_en_t           byte_en;
    } dec_t;

    // id/ex register
    typedef struct packed {
        dec_t  dec;
        // read in id, write-first bypass included
        word_t rs_data;
        word_t rt_data;
    } idex_t;

    // ex/mem, mem/wb and the write port
    typedef struct packed {
        logic               valid;
        isa_pkg::reg_addr_t addr;
        word_t              data;
        byte_en_t           byte_en;
    } wb_t;

endpackage

`default_nettype wire

// File: logic/instr_decode.sv
`timescale 1ns/1ps
`default_nettype none

module instr_decode (
    input  isa_pkg::instr_u    instr,
    input  logic               instr_valid,
    output isa_pkg::reg_addr_t rs_addr,
    output isa_pkg::reg_addr_t rt_addr,
    output pipe_pkg::dec_t     dec
);
    import isa_pkg::*;

    // opcode, and funct for r-type, recognised
    logic known;

    always_comb begin
        dec     = '0;
        known   = 1'b0;
        // rs and rt share bit positions in both formats
        rs_addr = instr.r_fields.rs;
        rt_addr = instr.r_fields.rt;
        if (instr.r_fields.opcode == OP_RTYPE) begin
            // r-type, writes rd, all bytes
            dec.rd_addr = instr.r_fields.rd;
            dec.byte_en = 4'b1111;
            known       = 1'b1;
            case (instr.r_fields.funct)
                FN_ADD:  dec.alu_op = ALU_ADD;
                FN_SUB:  dec.alu_op = ALU_SUB;
                FN_AND:  dec.alu_op = ALU_AND;
                FN_OR:   dec.alu_op = ALU_OR;
                FN_XOR:  dec.alu_op = ALU_XOR;
                FN_SLT:  dec.alu_op = ALU_SLT;
                default: known = 1'b0;
            endcase
        end else begin
            // i-type, rt is the destination
            dec.rd_addr = instr.i_fields.rt;
            dec.imm     = instr.i_fields.imm;
            known       = 1'b1;
            case (instr.i_fields.opcode)
                OP_ADDI: begin
                    dec.alu_op  = ALU_ADDI;
                    dec.byte_en = 4'b1111;
                end
                OP_ORI: begin
                    dec.alu_op  = ALU_ORI;
                    dec.byte_en = 4'b1111;
                end
                // half-word loads, two bytes only
                OP_LHI: begin
                    dec.alu_op  = ALU_LHI;
                    dec.byte_en = 4'b1100;
                end
                OP_LLO: begin
                    dec.alu_op  = ALU_LLO;
                    dec.byte_en = 4'b0011;
                end
                default: known = 1'b0;
            endcase
        end
        dec.rs_addr = rs_addr;
        dec.rt_addr = rt_addr;
        // r0 destination or bad code -> bubble
        dec.valid   = instr_valid && known && (dec.rd_addr != '0);
    end

endmodule

`default_nettype wire

// File: logic/reg_file.sv
`timescale 1ns/1ps
`default_nettype none

`include "core_config.svh"

module reg_file (
    input  logic               clk,
    input  logic               rst_n,
    input  isa_pkg::reg_addr_t rs_addr,
    input  isa_pkg::reg_addr_t rt_addr,
    output pipe_pkg::word_t    rs_data,
    output pipe_pkg::word_t    rt_data,
    input  pipe_pkg::wb_t      wr
);
    import isa_pkg::*;
    import pipe_pkg::*;

    // architectural registers
    word_t regs [`CORE_NREG];

    // stored word, then same-cycle write merged per byte
    function automatic word_t rd_port(
        input reg_addr_t addr,
        input word_t     stored,
        input wb_t       w
    );
        word_t rdata;
        rdata = stored;
        if (w.valid && (w.addr == addr)) begin
            for (int b = 0; b < $bits(byte_en_t); b++) begin
                if (w.byte_en[b])
                    rdata[8*b +: 8] = w.data[8*b +: 8];
            end
        end
        // r0 hardwired
        if (addr == '0)
            rdata = '0;
        return rdata;
    endfunction

    ////////////////////////////////////////
    // write port
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < `CORE_NREG; i++)
                regs[i] <= '0;
        end else if (wr.valid && (wr.addr != '0)) begin
            // enabled lanes only
            for (int b = 0; b < $bits(byte_en_t); b++) begin
                if (wr.byte_en[b])
                    regs[wr.addr][8*b +: 8] <= wr.data[8*b +: 8];
            end
        end
    end

    ////////////////////////////////////////
    // read ports, write-first
    ////////////////////////////////////////

    always_comb begin
        rs_data = rd_port(rs_addr, regs[rs_addr], wr);
        rt_data = rd_port(rt_addr, regs[rt_addr], wr);
    end

endmodule

`default_nettype wire

// File: logic/forward_unit.sv
`timescale 1ns/1ps
`default_nettype none

module forward_unit (
    input  pipe_pkg::idex_t idex,
    input  pipe_pkg::wb_t   exmem,
    input  pipe_pkg::wb_t   memwb,
    output pipe_pkg::word_t operand_a,
    output pipe_pkg::word_t operand_b
);
    import isa_pkg::*;
    import pipe_pkg::*;

    // stage b holds a live copy of byte b of src
    function automatic logic hit(
        input wb_t       stage,
        input reg_addr_t src,
        input int        b
    );
        return stage.valid && (stage.addr == src) && (src != '0) && stage.byte_en[b];
    endfunction

    ////////////////////////////////////////
    // per-byte operand select
    ////////////////////////////////////////

    // priority ex/mem, then mem/wb, then id read
    function automatic word_t pick(
        input reg_addr_t src,
        input word_t     rf_data,
        input wb_t       ex,
        input wb_t       mw
    );
        word_t op;
        op = rf_data;
        for (int b = 0; b < $bits(byte_en_t); b++) begin
            if (hit(ex, src, b))
                op[8*b +: 8] = ex.data[8*b +: 8];
            else if (hit(mw, src, b))
                op[8*b +: 8] = mw.data[8*b +: 8];
        end
        return op;
    endfunction

    // lhi then llo on the same reg leaves the halves in different stages,
    // so each lane resolves on its own
    always_comb begin
        operand_a = pick(idex.dec.rs_addr, idex.rs_data, exmem, memwb);
        operand_b = pick(idex.dec.rt_addr, idex.rt_data, exmem, memwb);
    end

endmodule

`default_nettype wire

// File: logic/alu.sv
`timescale 1ns/1ps
`default_nettype none

`include "core_config.svh"

module alu (
    input  isa_pkg::alu_op_e alu_op,
    input  pipe_pkg::word_t  operand_a,
    input  pipe_pkg::word_t  operand_b,
    input  logic [15:0]      imm,
    output pipe_pkg::word_t  result
);
    import isa_pkg::*;
    import pipe_pkg::*;

    // immediate extensions
    word_t imm_sext;
    word_t imm_zext;

    assign imm_sext = {{(`CORE_XLEN-16){imm[15]}}, imm};
    assign imm_zext = {{(`CORE_XLEN-16){1'b0}}, imm};

    always_comb begin
        result = '0;
        case (alu_op)
            ALU_ADD:  result = operand_a + operand_b;
            ALU_SUB:  result = operand_a - operand_b;
            ALU_AND:  result = operand_a & operand_b;
            ALU_OR:   result = operand_a | operand_b;
            ALU_XOR:  result = operand_a ^ operand_b;
            // signed compare, 0 or 1
            ALU_SLT:  result = {{(`CORE_XLEN-1){1'b0}}, $signed(operand_a) < $signed(operand_b)};
            ALU_ADDI: result = operand_a + imm_sext;
            ALU_ORI:  result = operand_a | imm_zext;
            // upper half, lower lanes not written
            ALU_LHI:  result = {imm, {(`CORE_XLEN-16){1'b0}}};
            // lower half, upper lanes not written
            ALU_LLO:  result = imm_zext;
            default:  result = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: logic/exec_pipe.sv
`timescale 1ns/1ps
`default_nettype none

module exec_pipe (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            instr_valid,
    input  isa_pkg::instr_u instr,
    output pipe_pkg::wb_t   wb
);
    import isa_pkg::*;
    import pipe_pkg::*;

    // id stage
    reg_addr_t rs_addr;
    reg_addr_t rt_addr;
    dec_t      dec;
    word_t     rs_data;
    word_t     rt_data;

    // ex stage
    idex_t     idex_q;
    word_t     operand_a;
    word_t     operand_b;
    word_t     alu_result;

    // mem and wb stages
    wb_t       exmem_q;
    wb_t       memwb_q;

    ////////////////////////////////////////
    // id: decode and register read
    ////////////////////////////////////////

    instr_decode u_decode (
        .instr       (instr),
        .instr_valid (instr_valid),
        .rs_addr     (rs_addr),
        .rt_addr     (rt_addr),
        .dec         (dec)
    );

    // write port fed from mem/wb
    reg_file u_regs (
        .clk     (clk),
        .rst_n   (rst_n),
        .rs_addr (rs_addr),
        .rt_addr (rt_addr),
        .rs_data (rs_data),
        .rt_data (rt_data),
        .wr      (memwb_q)
    );

    // payload follows every edge, valid cleared on reset
    always_ff @(posedge clk) begin
        idex_q <= '{dec: dec, rs_data: rs_data, rt_data: rt_data};
        if (!rst_n)
            idex_q.dec.valid <= 1'b0;
    end

    ////////////////////////////////////////
    // ex: forward and compute
    ////////////////////////////////////////

    forward_unit u_fwd (
        .idex      (idex_q),
        .exmem     (exmem_q),
        .memwb     (memwb_q),
        .operand_a (operand_a),
        .operand_b (operand_b)
    );

    alu u_alu (
        .alu_op    (idex_q.dec.alu_op),
        .operand_a (operand_a),
        .operand_b (operand_b),
        .imm       (idex_q.dec.imm),
        .result    (alu_result)
    );

    always_ff @(posedge clk) begin
        exmem_q <= '{valid:   idex_q.dec.valid,
                     addr:    idex_q.dec.rd_addr,
                     data:    alu_result,
                     byte_en: idex_q.dec.byte_en};
        if (!rst_n)
            exmem_q.valid <= 1'b0;
    end

    ////////////////////////////////////////
    // mem: no memory, result carried on
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        memwb_q <= exmem_q;
        if (!rst_n)
            memwb_q.valid <= 1'b0;
    end

    // wb port mirrors the register-file write
    assign wb = memwb_q;

endmodule

`default_nettype wire

// File: test/exec_pipe_assert.sv
`timescale 1ns/1ps
`default_nettype none

`include "core_config.svh"

module exec_pipe_assert (
    input logic          clk,
    input logic          rst_n,
    input logic          instr_valid,
    input pipe_pkg::wb_t wb
);

    // edges since reset release, stops counting at the wb latency
    int since_rst;

    always_ff @(posedge clk) begin
        if (!rst_n)
            since_rst <= 0;
        else if (since_rst < `CORE_WB_LAT)
            since_rst <= since_rst + 1;
    end

    ////////////////////////////////////////
    // write-back port
    ////////////////////////////////////////

    // pipe still filling, nothing can come out yet
    no_early_wb: assert property (
        @(posedge clk) disable iff (!rst_n)
        (since_rst < `CORE_WB_LAT) |-> !wb.valid
    ) else $error("wb.valid high within %0d cycles of reset", `CORE_WB_LAT);

    // r0 writes are bubbles, every real write has lanes
    wb_well_formed: assert property (
        @(posedge clk) disable iff (!rst_n)
        wb.valid |-> (wb.addr != '0) && (wb.byte_en != '0)
    ) else $error("wb valid with address %0d, byte enables %b", wb.addr, wb.byte_en);

    // every write-back traces back to an accepted word
    wb_has_source: assert property (
        @(posedge clk) disable iff (!rst_n)
        wb.valid |-> $past(instr_valid, `CORE_WB_LAT)
    ) else $error("wb valid without instr_valid %0d cycles earlier", `CORE_WB_LAT);

endmodule

bind exec_pipe exec_pipe_assert u_assert (
    .clk         (clk),
    .rst_n       (rst_n),
    .instr_valid (instr_valid),
    .wb          (wb)
);

`default_nettype wire

// File: test/tb_exec_pipe.sv
`timescale 1ns/1ps
`default_nettype none

`include "core_config.svh"

module tb_exec_pipe;
    import isa_pkg::*;
    import pipe_pkg::*;

    // stim columns: word, kind, addr, byte enables, data
    localparam int STIM_COLS = 5;
    localparam int STIM_MAX  = 64;
    localparam logic [31:0] KIND_NO_WB = 32'h0;
    localparam logic [31:0] KIND_WB    = 32'h1;
    localparam logic [31:0] KIND_GAP   = 32'h2;
    localparam logic [31:0] KIND_END   = 32'hf;
    // drain budget, well past the wb latency
    localparam int DRAIN_LIMIT = 20;

    // one queued write-back
    typedef struct packed {
        logic [31:0] cycle;
        reg_addr_t   addr;
        byte_en_t    byte_en;
        word_t       data;
    } wb_exp_t;

    logic        clk         = 1'b0;
    logic        rst_n       = 1'b0;
    logic        instr_valid = 1'b0;
    instr_u      instr       = '0;
    wb_t         wb;
    logic [31:0] cycle       = '0;
    logic [31:0] stim [STIM_COLS*STIM_MAX];
    wb_exp_t     pending_q [$];
    wb_exp_t     head;
    int          checks        = 0;
    int          value_errors  = 0;
    int          unexpected_wb = 0;
    int          stim_errors   = 0;

    always #10 clk = ~clk;

    // edge count, read before its update
    always @(posedge clk)
        cycle <= cycle + 32'd1;

    exec_pipe uut (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr_valid (instr_valid),
        .instr       (instr),
        .wb          (wb)
    );

    ////////////////////////////////////////
    // helpers
    ////////////////////////////////////////

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            value_errors++;
            $display("[ERROR] %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    // one word on the bus; queue its wb if it writes
    task automatic issue_instr(input logic [31:0] word, input logic want_wb,
                               input logic [31:0] addr, input logic [31:0] be,
                               input logic [31:0] data);
        wb_exp_t e;
        @(posedge clk);
        instr_valid <= 1'b1;
        instr       <= word;
        if (want_wb) begin
            // accepted next edge, then the wb latency
            e.cycle   = cycle + 32'd1 + `CORE_WB_LAT;
            e.addr    = reg_addr_t'(addr);
            e.byte_en = byte_en_t'(be);
            e.data    = data;
            pending_q.push_back(e);
        end
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            instr_valid <= 1'b0;
            instr       <= '0;
        end
    endtask

    ////////////////////////////////////////
    // wb monitor, mid-cycle
    ////////////////////////////////////////

    always @(negedge clk) begin
        if (rst_n && wb.valid) begin
            if (pending_q.size() == 0) begin
                unexpected_wb++;
                $display("unexpected write-back to r%0d at %0t, none was queued",
                         wb.addr, $time);
            end else begin
                head = pending_q.pop_front();
                check_value("write-back cycle", cycle, head.cycle);
                check_value("write-back address", 32'(wb.addr), 32'(head.addr));
                check_value("write-back byte enables", 32'(wb.byte_en), 32'(head.byte_en));
                check_value("write-back data", wb.data, head.data);
            end
        end
    end

    ////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////

    initial begin
        int          idx;
        int          drain;
        logic        done;
        logic [31:0] kind;
        void'($urandom(32'hf6af));
        $readmemh("test/exec_stim.txt", stim);
        // three edges in reset
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;

        idx  = 0;
        done = 1'b0;
        while (!done && idx < STIM_MAX) begin
            kind = stim[STIM_COLS*idx+1];
            if (kind == KIND_END) begin
                done = 1'b1;
            end else if (kind == KIND_GAP) begin
                idle_cycles(int'($urandom_range(4, 1)));
            end else if (kind == KIND_WB || kind == KIND_NO_WB) begin
                issue_instr(stim[STIM_COLS*idx], kind == KIND_WB, stim[STIM_COLS*idx+2],
                            stim[STIM_COLS*idx+3], stim[STIM_COLS*idx+4]);
            end else begin
                stim_errors++;
                $display("stimulus line %0d has unknown kind %h", idx, kind);
            end
            idx++;
        end
        if (!done) begin
            stim_errors++;
            $display("stimulus file missing or without its end line");
        end
        idle_cycles(1);

        // drain the pipe
        drain = 0;
        while (pending_q.size() != 0 && drain < DRAIN_LIMIT) begin
            @(posedge clk);
            drain++;
        end
        if (pending_q.size() != 0) begin
            $display("timeout: %0d expected write-backs never appeared", pending_q.size());
            $display("checks %0d, value errors %0d, unexpected wb %0d, stimulus errors %0d",
                     checks, value_errors, unexpected_wb, stim_errors);
            $display("FAIL: see errors above");
            $finish;
        end else begin
            // stray writes would show up here
            idle_cycles(`CORE_WB_LAT + 1);
            $display("checks %0d, value errors %0d, unexpected wb %0d, stimulus errors %0d",
                     checks, value_errors, unexpected_wb, stim_errors);
            if (value_errors + unexpected_wb + stim_errors == 0)
                $display("PASS: all tests");
            else
                $display("FAIL: see errors above");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: build.f
+incdir+common
common/isa_pkg.sv
common/pipe_pkg.sv
logic/instr_decode.sv
logic/reg_file.sv
logic/forward_unit.sv
logic/alu.sv
logic/exec_pipe.sv
test/exec_pipe_assert.sv
test/tb_exec_pipe.sv

// File: run_sim.sh
#!/bin/sh
# build and run tb_exec_pipe with Verilator
# the result is taken from the simulation log

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=sim_exec_pipe

verilator --binary --timing --assert \
    --top-module tb_exec_pipe \
    --Mdir obj_dir -o "$BIN" \
    -f build.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/"$BIN" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -qx "PASS: all tests" "$LOG"; then
    exit 0
fi
echo "pass line not found in $LOG"
exit 1

// File: test/exec_stim.txt
// instr    kind addr be data      (all hex)
// kind 0 no write-back, 1 write-back expected, 2 random idle gap, f end
// ex/mem forward r3, mem/wb forward r6, id bypass r1 and r5
20010011 1 01 f 00000011
20020022 1 02 f 00000022
00221820 1 03 f 00000033
00612822 1 05 f 00000022
340600f0 1 06 f 000000f0
20070007 1 07 f 00000007
00c54026 1 08 f 000000d2
00000000 2 00 0 00000000
// r1 written three times, newest copy wins
20210100 1 01 f 00000111
20211000 1 01 f 00001111
00210820 1 01 f 00002222
00204825 1 09 f 00002222
00000000 2 00 0 00000000
// lhi then llo, halves from mem/wb and ex/mem
6401abcd 1 01 c abcd0000
60015678 1 01 3 00005678
00205020 1 0a f abcd5678
00000000 2 00 0 00000000
// partial writes mixed with register file bytes
60019999 1 01 3 00009999
00222026 1 04 f abcd99bb
64027777 1 02 c 77770000
00e6582a 1 0b f 00000001
00406025 1 0c f 77770022
00000000 2 00 0 00000000
// r0 destinations, r0 reads, id bypass, bad funct
20000055 0 00 0 00000000
340d1234 1 0d f 00001234
012a7824 1 0f f 00000220
000d8022 1 10 f ffffedcc
01a08820 1 11 f 00001234
01ad0025 0 00 0 00000000
0200902a 1 12 f 00000001
00221800 0 00 0 00000000
00000000 f 00 0 00000000
